// File: video_core.f
+incdir+include
source/video_pkg.sv
source/video_ifs.sv
source/video_cfg_regs.sv
source/frame_fetcher.sv
source/pixel_fifo.sv
source/video_timing.sv
source/pixel_unpacker.sv
source/video_core.sv
test/tb_video_core.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS = --timing -Wno-fatal
TOP = tb_video_core
FILELIST = video_core.f
OBJ_DIR = obj_dir
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; true
	cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: test/tb_video_core_input.txt
// first word: number of cases, then one case per line
// columns: format (0 rgb888, 1 rgb565), enable, base word address, stall level of 16, frames
6
0 1 00001000 2 2
0 1 00002340 8 2
1 1 00000800 2 2
1 1 00003000 8 1
0 0 00001000 2 1
0 1 00000010 4 2

// File: test/tb_video_core.sv
`default_nettype none

module tb_video_core
	import video_pkg::*;
;
	localparam int H_ACTIVE = 16, H_FRONT = 2, H_SYNC = 3, H_BACK = 3;
	localparam int V_ACTIVE = 4, V_FRONT = 1, V_SYNC = 1, V_BACK = 2;
	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
	localparam int FRAME = H_TOTAL * V_TOTAL;

	logic clk_i, pixel_rstn_i, cfg_cyc_i, cfg_stb_i, cfg_we_i, cfg_ack_o;
	logic [1:0] cfg_adr_i;
	logic [31:0] cfg_dat_i, cfg_dat_o, fb_dat_i;
	logic fb_cyc_o, fb_stb_o, fb_stall_i, fb_ack_i, hsync_o, vsync_o, de_o;
	logic [29:0] fb_adr_o;
	logic [23:0] rgb_o;
	logic [31:0] case_mem [0:127];
	int stall_level = 0;
	int limit = 0;

	video_core #(.H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
		.V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
		.FIFO_DEPTH(64)) i_video_core (.*);

	initial begin
		clk_i = 1'b0;
		forever #2 clk_i = ~clk_i;
	end

	// watchdog armed once the case list is known
	initial begin
		int cycles;
		cycles = 0;
		forever begin
			@(posedge clk_i);
			cycles++;
			if (limit > 0 && cycles > limit) begin
				$display("timeout: video output stopped making progress after %0d cycles", cycles);
				$display("TEST FAILED");
				$fatal(1);
			end
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s ^= s << 13;
		s ^= s >> 17;
		s ^= s << 5;
		return s;
	endfunction

	function automatic logic [31:0] mem_word(input logic [29:0] a);
		return 32'({2'b0, a} * 32'h9E37_79B1);
	endfunction

	// memory model with stall and ack decided 1 unit after each edge
	initial begin
		logic [31:0] rnd;
		logic [29:0] adr_q [$];
		int due_q [$];
		int tick_n, last_due, due;
		logic req_seen;
		logic [29:0] req_adr;
		rnd = 32'd61;
		tick_n = 0;
		last_due = 0;
		req_seen = 1'b0;
		req_adr = '0;
		forever begin
			@(posedge clk_i);
			#1;
			tick_n++;
			if (req_seen) begin
				rnd = xorshift(rnd);
				// latency of 1 to 3 cycles kept in order
				due = tick_n - 1 + 1 + int'(rnd % 3);
				if (due <= last_due) due = last_due + 1;
				last_due = due;
				adr_q.push_back(req_adr);
				due_q.push_back(due);
			end
			// cyc must cover each request and each outstanding read
			if (!fb_cyc_o && (fb_stb_o || due_q.size() > 0)) begin
				stop_with_error("fb_cyc_o was low during a request or with reads outstanding");
			end
			if (due_q.size() > 0 && due_q[0] <= tick_n) begin
				fb_ack_i = 1'b1;
				fb_dat_i = mem_word(adr_q.pop_front());
				void'(due_q.pop_front());
			end else begin
				fb_ack_i = 1'b0;
				fb_dat_i = '0;
			end
			rnd = xorshift(rnd);
			fb_stall_i = int'(rnd[3:0]) < stall_level;
			req_seen = fb_stb_o && !fb_stall_i;
			req_adr = fb_adr_o;
		end
	end

	task automatic stop_with_error(input string msg);
		$display("%s at time %0t", msg, $time);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic check_rgb(input logic [23:0] got, input logic [23:0] exp, input string msg);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s, got %h expected %h", $time, msg, got, exp);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string msg);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s, got %h expected %h", $time, msg, got, exp);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_fmt(input pix_fmt_e got, input pix_fmt_e exp, input string msg);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s, got %s expected %s", $time, msg, got.name(),
				exp.name());
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	task automatic next_cycle();
		@(posedge clk_i);
		#1;
	endtask

	// one classic access whose ack must come and last a single cycle
	task automatic bus_access(input logic we, input logic [1:0] adr, input logic [31:0] wdata,
		output logic [31:0] rdata);
		int waited;
		waited = 0;
		cfg_cyc_i = 1'b1;
		cfg_stb_i = 1'b1;
		cfg_we_i = we;
		cfg_adr_i = adr;
		cfg_dat_i = wdata;
		next_cycle();
		while (!cfg_ack_o) begin
			waited++;
			if (waited > 4) stop_with_error("config port never acknowledged the access");
			next_cycle();
		end
		rdata = cfg_dat_o;
		cfg_cyc_i = 1'b0;
		cfg_stb_i = 1'b0;
		cfg_we_i = 1'b0;
		next_cycle();
		if (cfg_ack_o) stop_with_error("config port gave more than one ack for an access");
	endtask

	// rgb565 channels widened by copying their top bits into the low bits
	function automatic logic [23:0] expected_pixel(input pix_fmt_e fmt, input logic en,
		input logic [29:0] base, input int n);
		logic [31:0] w;
		logic [15:0] h;
		if (!en) return '0;
		if (fmt == PIX_RGB888) return mem_word(base + 30'(n)) & 32'hFF_FFFF;
		w = mem_word(base + 30'(n / 2));
		h = (n % 2 == 0) ? w[15:0] : w[31:16];
		return {h[15:11], 3'(h[15:11] >> 2), h[10:5], 2'(h[10:5] >> 4), h[4:0],
			3'(h[4:0] >> 2)};
	endfunction

	// one full frame window starting at the first active output pixel
	task automatic check_frame(input pix_fmt_e fmt, input logic en, input logic [29:0] base);
		int hs_cnt [V_TOTAL];
		int n, line, vs_cnt, vs_lines;
		logic vs_seen;
		n = 0;
		vs_cnt = 0;
		vs_lines = 0;
		vs_seen = 1'b0;
		foreach (hs_cnt[l]) hs_cnt[l] = 0;
		while (!de_o) next_cycle();
		for (int i = 0; i < FRAME; i++) begin
			line = i / H_TOTAL;
			if (i % H_TOTAL == 0) vs_seen = 1'b0;
			if (de_o) begin
				check_rgb(rgb_o, expected_pixel(fmt, en, base, n),
					$sformatf("pixel %0d", n));
				n++;
			end else begin
				check_rgb(rgb_o, '0, "rgb outside active video");
			end
			if (hsync_o) hs_cnt[line]++;
			if (vsync_o) begin
				vs_cnt++;
				if (!vs_seen) vs_lines++;
				vs_seen = 1'b1;
			end
			next_cycle();
		end
		check_word(32'(n), 32'(H_ACTIVE * V_ACTIVE), "de cycles per frame");
		foreach (hs_cnt[l]) check_word(32'(hs_cnt[l]), 32'(H_SYNC), $sformatf("hsync line %0d", l));
		check_word(32'(vs_lines), 32'(V_SYNC), "vsync lines per frame");
		check_word(32'(vs_cnt), 32'(V_SYNC * H_TOTAL), "vsync cycles per frame");
	endtask

	initial begin
		int cases, frames_sum, base_i, frames;
		pix_fmt_e fmt;
		logic en;
		logic [29:0] base;
		logic [31:0] rd;
		pixel_rstn_i = 1'b0;
		cfg_cyc_i = 1'b0;
		cfg_stb_i = 1'b0;
		cfg_we_i = 1'b0;
		cfg_adr_i = '0;
		cfg_dat_i = '0;
		fb_stall_i = 1'b0;
		fb_ack_i = 1'b0;
		fb_dat_i = '0;
		$readmemh("test/tb_video_core_input.txt", case_mem);
		cases = int'(case_mem[0]);
		if (cases <= 0) stop_with_error("input file holds no test cases");
		frames_sum = 0;
		for (int c = 0; c < cases; c++) frames_sum += int'(case_mem[1 + c * 5 + 4]);
		// each case also skips a frame and waits out one more
		limit = frames_sum * FRAME * 2 + cases * 4 * FRAME + 200;
		repeat (2) @(posedge clk_i);
		#1;
		pixel_rstn_i = 1'b1;
		for (int c = 0; c < cases; c++) begin
			base_i = 1 + c * 5;
			fmt = pix_fmt_e'(case_mem[base_i][0]);
			en = case_mem[base_i + 1][0];
			base = case_mem[base_i + 2][29:0];
			stall_level = int'(case_mem[base_i + 3]);
			frames = int'(case_mem[base_i + 4]);
			bus_access(1'b1, REG_CTRL, 32'h0, rd);
			bus_access(1'b1, REG_STATUS, 32'h1, rd);
			bus_access(1'b1, REG_FB_BASE, {2'b0, base}, rd);
			bus_access(1'b1, REG_CTRL, {30'b0, fmt, en}, rd);
			bus_access(1'b0, REG_FB_BASE, '0, rd);
			check_word(rd, {2'b0, base}, "FB_BASE readback");
			bus_access(1'b0, REG_CTRL, '0, rd);
			check_fmt(pix_fmt_e'(rd[1]), fmt, "CTRL format readback");
			check_word({rd[31:2], 1'b0, rd[0]}, {31'b0, en}, "CTRL readback");
			// the frame after the change may still come from the old setup
			while (de_o) next_cycle();
			while (!de_o) next_cycle();
			while (!vsync_o) next_cycle();
			bus_access(1'b1, REG_STATUS, 32'h1, rd);
			for (int f = 0; f < frames; f++) check_frame(fmt, en, base);
			// end of the next active area where the fetch is done and the next has not begun
			while (!de_o) next_cycle();
			repeat (H_TOTAL * (V_ACTIVE - 1) + H_ACTIVE) next_cycle();
			bus_access(1'b0, REG_STATUS, '0, rd);
			check_word(rd, en ? 32'h0 : 32'h1, "STATUS after frames");
			if (!en) begin
				bus_access(1'b1, REG_STATUS, 32'h1, rd);
				next_cycle();
				bus_access(1'b0, REG_STATUS, '0, rd);
				check_word(rd, 32'h0, "STATUS after underflow clear");
			end
		end
		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: source/video_core.sv
`default_nettype none

`include "video_consts.svh"

module video_core
	import video_pkg::*;
#(
	parameter int H_ACTIVE = `VID_H_ACTIVE,
	parameter int H_FRONT = `VID_H_FRONT,
	parameter int H_SYNC = `VID_H_SYNC,
	parameter int H_BACK = `VID_H_BACK,
	parameter int V_ACTIVE = `VID_V_ACTIVE,
	parameter int V_FRONT = `VID_V_FRONT,
	parameter int V_SYNC = `VID_V_SYNC,
	parameter int V_BACK = `VID_V_BACK,
	parameter int FIFO_DEPTH = `VID_FIFO_DEPTH
) (
	input wire clk_i,
	input wire pixel_rstn_i,
	// config port, wishbone classic
	input wire cfg_cyc_i,
	input wire cfg_stb_i,
	input wire cfg_we_i,
	input wire [1:0] cfg_adr_i,
	input wire [31:0] cfg_dat_i,
	output logic [31:0] cfg_dat_o,
	output logic cfg_ack_o,
	// framebuffer port, pipelined wishbone read
	output logic fb_cyc_o,
	output logic fb_stb_o,
	output logic [29:0] fb_adr_o,
	input wire fb_stall_i,
	input wire fb_ack_i,
	input wire [31:0] fb_dat_i,
	// parallel video out
	output logic [23:0] rgb_o,
	output logic hsync_o,
	output logic vsync_o,
	output logic de_o
);
	localparam int X_W = $clog2(H_ACTIVE + H_FRONT + H_SYNC + H_BACK);
	localparam int Y_W = $clog2(V_ACTIVE + V_FRONT + V_SYNC + V_BACK);

	video_config_t video_config;
	logic underflow;
	logic fetch_busy;

	fb_fifo_if #(.DEPTH(FIFO_DEPTH)) i_fifo_if ();
	vid_timing_if #(.X_WIDTH(X_W), .Y_WIDTH(Y_W)) i_timing_if ();

	video_cfg_regs i_cfg_regs (
		.clk_i(clk_i),
		.pixel_rstn_i(pixel_rstn_i),
		.cyc_i(cfg_cyc_i),
		.stb_i(cfg_stb_i),
		.we_i(cfg_we_i),
		.adr_i(cfg_reg_e'(cfg_adr_i)),
		.dat_i(cfg_dat_i),
		.dat_o(cfg_dat_o),
		.ack_o(cfg_ack_o),
		.underflow_i(underflow),
		.fetch_busy_i(fetch_busy),
		.config_o(video_config)
	);

	// fetch side fills the fifo during vertical blanking and beyond
	frame_fetcher #(
		.H_ACTIVE(H_ACTIVE),
		.V_ACTIVE(V_ACTIVE),
		.FIFO_DEPTH(FIFO_DEPTH)
	) i_frame_fetcher (
		.clk_i(clk_i),
		.pixel_rstn_i(pixel_rstn_i),
		.config_i(video_config),
		.timing(i_timing_if),
		.fifo(i_fifo_if),
		.fb_cyc_o(fb_cyc_o),
		.fb_stb_o(fb_stb_o),
		.fb_adr_o(fb_adr_o),
		.fb_stall_i(fb_stall_i),
		.fb_ack_i(fb_ack_i),
		.fb_dat_i(fb_dat_i),
		.busy_o(fetch_busy)
	);

	pixel_fifo #(.DEPTH(FIFO_DEPTH)) i_pixel_fifo (
		.clk_i(clk_i),
		.pixel_rstn_i(pixel_rstn_i),
		.fifo(i_fifo_if)
	);

	video_timing #(
		.H_ACTIVE(H_ACTIVE),
		.H_FRONT(H_FRONT),
		.H_SYNC(H_SYNC),
		.H_BACK(H_BACK),
		.V_ACTIVE(V_ACTIVE),
		.V_FRONT(V_FRONT),
		.V_SYNC(V_SYNC),
		.V_BACK(V_BACK)
	) i_video_timing (
		.clk_i(clk_i),
		.pixel_rstn_i(pixel_rstn_i),
		.timing(i_timing_if)
	);

	// joins fifo words with the display counters
	pixel_unpacker i_pixel_unpacker (
		.clk_i(clk_i),
		.pixel_rstn_i(pixel_rstn_i),
		.config_i(video_config),
		.timing(i_timing_if),
		.fifo(i_fifo_if),
		.rgb_o(rgb_o),
		.hsync_o(hsync_o),
		.vsync_o(vsync_o),
		.de_o(de_o),
		.underflow_o(underflow)
	);

endmodule

`default_nettype wire

// File: source/pixel_unpacker.sv
`default_nettype none

module pixel_unpacker
	import video_pkg::*;
(
	input wire clk_i,
	input wire pixel_rstn_i,
	input wire video_config_t config_i,
	vid_timing_if.pixel timing,
	fb_fifo_if.reader fifo,
	output logic [23:0] rgb_o,
	output logic hsync_o,
	output logic vsync_o,
	output logic de_o,
	output logic underflow_o
);
	// format of the frame being fetched, then of the frame on screen
	pix_fmt_e fmt_next_q;
	pix_fmt_e fmt_q;
	pix_fmt_e fmt;
	logic need_word;
	logic [15:0] high_q;
	logic [15:0] half;
	logic [23:0] pixel;

	// widen 5/6/5 to 8 bits per channel by repeating the top bits
	function automatic logic [23:0] expand565(input logic [15:0] w);
		return {w[15:11], w[15:13], w[10:5], w[10:9], w[4:0], w[4:2]};
	endfunction

	// the first pixel of a frame already uses the new format
	assign fmt = timing.frame_start ? fmt_next_q : fmt_q;
	// rgb565 takes a fresh word on even x only
	assign need_word = timing.de & ((fmt == PIX_RGB888) | ~timing.x[0]);
	assign fifo.pop = need_word & ~fifo.empty;
	assign half = timing.x[0] ? high_q : fifo.rdata[15:0];

	// black whenever the word is missing
	always_comb begin
		pixel = '0;
		if (timing.de) begin
			if (fmt == PIX_RGB888) begin
				if (!fifo.empty) begin
					pixel = fifo.rdata[23:0];
				end
			end else if (timing.x[0] || !fifo.empty) begin
				pixel = expand565(half);
			end
		end
	end

	// upper rgb565 pixel kept for the odd x, zero if the word never came
	always_ff @(posedge clk_i) begin
		if (need_word && fmt == PIX_RGB565) begin
			high_q <= fifo.empty ? '0 : fifo.rdata[31:16];
		end
	end

	always_ff @(posedge clk_i or negedge pixel_rstn_i) begin
		if (!pixel_rstn_i) begin
			fmt_next_q <= PIX_RGB888;
			fmt_q <= PIX_RGB888;
			rgb_o <= '0;
			hsync_o <= 1'b0;
			vsync_o <= 1'b0;
			de_o <= 1'b0;
			underflow_o <= 1'b0;
		end else begin
			if (timing.fetch_start) begin
				fmt_next_q <= config_i.fmt;
			end
			fmt_q <= fmt;
			// pixel and syncs move together, one cycle after the counters
			rgb_o <= pixel;
			hsync_o <= timing.hsync;
			vsync_o <= timing.vsync;
			de_o <= timing.de;
			underflow_o <= need_word & fifo.empty;
		end
	end

endmodule

`default_nettype wire

// File: source/video_timing.sv
`default_nettype none

`include "video_consts.svh"

module video_timing #(
	parameter int H_ACTIVE = `VID_H_ACTIVE,
	parameter int H_FRONT = `VID_H_FRONT,
	parameter int H_SYNC = `VID_H_SYNC,
	parameter int H_BACK = `VID_H_BACK,
	parameter int V_ACTIVE = `VID_V_ACTIVE,
	parameter int V_FRONT = `VID_V_FRONT,
	parameter int V_SYNC = `VID_V_SYNC,
	parameter int V_BACK = `VID_V_BACK
) (
	input wire clk_i,
	input wire pixel_rstn_i,
	vid_timing_if.driver timing
);
	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
	localparam int X_W = $clog2(H_TOTAL);
	localparam int Y_W = $clog2(V_TOTAL);
	// sync windows begin right after the front porch
	localparam int HS_START = H_ACTIVE + H_FRONT;
	localparam int VS_START = V_ACTIVE + V_FRONT;

	logic [X_W-1:0] x_q;
	logic [Y_W-1:0] y_q;
	logic line_end;

	assign line_end = x_q == X_W'(H_TOTAL - 1);

	// reset lands on the first blanking line so a fetch comes before any active frame
	always_ff @(posedge clk_i or negedge pixel_rstn_i) begin
		if (!pixel_rstn_i) begin
			x_q <= '0;
			y_q <= Y_W'(V_ACTIVE);
		end else begin
			x_q <= line_end ? '0 : x_q + 1'b1;
			if (line_end) begin
				y_q <= (y_q == Y_W'(V_TOTAL - 1)) ? '0 : y_q + 1'b1;
			end
		end
	end

	assign timing.x = x_q;
	assign timing.y = y_q;
	assign timing.de = (int'(x_q) < H_ACTIVE) && (int'(y_q) < V_ACTIVE);
	assign timing.hsync = (int'(x_q) >= HS_START) && (int'(x_q) < HS_START + H_SYNC);
	assign timing.vsync = (int'(y_q) >= VS_START) && (int'(y_q) < VS_START + V_SYNC);
	assign timing.frame_start = (x_q == '0) && (y_q == '0);
	assign timing.fetch_start = (x_q == '0) && (int'(y_q) == V_ACTIVE);

endmodule

`default_nettype wire

// File: source/pixel_fifo.sv
`default_nettype none

`include "video_consts.svh"

module pixel_fifo #(
	// power of two, pointers wrap on their own
	parameter int DEPTH = `VID_FIFO_DEPTH
) (
	input wire clk_i,
	input wire pixel_rstn_i,
	fb_fifo_if.fifo fifo
);
	localparam int AW = $clog2(DEPTH);

	logic [31:0] mem [DEPTH];
	logic [AW-1:0] wr_ptr_q;
	logic [AW-1:0] rd_ptr_q;
	logic [AW:0] level_q;
	logic full;
	logic do_push;
	logic do_pop;

	assign full = level_q == (AW + 1)'(DEPTH);
	assign fifo.empty = level_q == '0;
	assign fifo.level = level_q;
	// head word read straight from the array
	assign fifo.rdata = mem[rd_ptr_q];

	// a push into a full fifo is lost
	assign do_push = fifo.push & ~full;
	assign do_pop = fifo.pop & ~fifo.empty;

	always_ff @(posedge clk_i) begin
		if (do_push) begin
			mem[wr_ptr_q] <= fifo.wdata;
		end
	end

	always_ff @(posedge clk_i or negedge pixel_rstn_i) begin
		if (!pixel_rstn_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			level_q <= '0;
		end else begin
			if (do_push) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (do_pop) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			// level only moves when exactly one side is active
			case ({do_push, do_pop})
				2'b10: level_q <= level_q + 1'b1;
				2'b01: level_q <= level_q - 1'b1;
				default: level_q <= level_q;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/frame_fetcher.sv
`default_nettype none

`include "video_consts.svh"

module frame_fetcher
	import video_pkg::*;
#(
	parameter int H_ACTIVE = `VID_H_ACTIVE,
	parameter int V_ACTIVE = `VID_V_ACTIVE,
	parameter int FIFO_DEPTH = `VID_FIFO_DEPTH
) (
	input wire clk_i,
	input wire pixel_rstn_i,
	input wire video_config_t config_i,
	vid_timing_if.fetch timing,
	fb_fifo_if.writer fifo,
	// pipelined wishbone read master
	output logic fb_cyc_o,
	output logic fb_stb_o,
	output logic [29:0] fb_adr_o,
	input wire fb_stall_i,
	input wire fb_ack_i,
	input wire [31:0] fb_dat_i,
	output logic busy_o
);
	localparam int WORDS = H_ACTIVE * V_ACTIVE;
	localparam int CNT_W = $clog2(WORDS + 1);
	localparam int LVL_W = $clog2(FIFO_DEPTH) + 1;
	// pending plus level needs one bit more than either
	localparam int SUM_W = LVL_W + 1;

	fetch_state_e state_q, state_d;
	logic [29:0] adr_q, adr_d;
	logic [CNT_W-1:0] left_q, left_d;
	logic [LVL_W-1:0] pending_q, pending_d;
	logic [SUM_W-1:0] credit;
	logic at_limit;
	logic near_limit;
	logic req_ok;

	// words already owed to the fifo, in flight or stored
	assign credit = SUM_W'(pending_q) + SUM_W'(fifo.level);
	assign at_limit = credit >= SUM_W'(FIFO_DEPTH - 1);
	// one more accepted request would hit the limit
	assign near_limit = (credit + 1'b1) >= SUM_W'(FIFO_DEPTH - 1);

	assign fb_cyc_o = state_q != IDLE;
	assign fb_stb_o = state_q == FETCHING;
	assign fb_adr_o = adr_q;
	assign req_ok = fb_stb_o & ~fb_stall_i;
	assign busy_o = state_q != IDLE;

	// every ack carries one word straight into the fifo
	assign fifo.push = fb_ack_i;
	assign fifo.wdata = fb_dat_i;

	always_comb begin
		pending_d = pending_q;
		if (req_ok) begin
			pending_d = pending_d + 1'b1;
		end
		if (fb_ack_i) begin
			pending_d = pending_d - 1'b1;
		end
	end

	always_comb begin
		state_d = state_q;
		adr_d = adr_q;
		left_d = left_q;
		case (state_q)
			IDLE: begin
				// base and word count are taken only here
				if (timing.fetch_start && config_i.enable) begin
					adr_d = config_i.fb_base;
					left_d = (config_i.fmt == PIX_RGB565) ? CNT_W'(WORDS / 2) : CNT_W'(WORDS);
					state_d = at_limit ? FIFO_FULL : FETCHING;
				end
			end
			FETCHING: begin
				if (req_ok) begin
					adr_d = adr_q + 1'b1;
					left_d = left_q - 1'b1;
				end
				if (left_d == '0) begin
					state_d = WAIT_OUTSTANDING;
				end else if (req_ok && near_limit) begin
					state_d = FIFO_FULL;
				end
			end
			// hold cyc while the unpacker drains the fifo
			FIFO_FULL: begin
				if (!at_limit) begin
					state_d = FETCHING;
				end
			end
			WAIT_OUTSTANDING: begin
				if (pending_d == '0) begin
					state_d = IDLE;
				end
			end
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk_i or negedge pixel_rstn_i) begin
		if (!pixel_rstn_i) begin
			state_q <= IDLE;
			adr_q <= '0;
			left_q <= '0;
			pending_q <= '0;
		end else begin
			state_q <= state_d;
			adr_q <= adr_d;
			left_q <= left_d;
			pending_q <= pending_d;
		end
	end

endmodule

`default_nettype wire

// File: source/video_cfg_regs.sv
`default_nettype none

module video_cfg_regs
	import video_pkg::*;
(
	input wire clk_i,
	input wire pixel_rstn_i,
	// wishbone classic slave
	input wire cyc_i,
	input wire stb_i,
	input wire we_i,
	input wire cfg_reg_e adr_i,
	input wire [31:0] dat_i,
	output logic [31:0] dat_o,
	output logic ack_o,
	// status sources
	input wire underflow_i,
	input wire fetch_busy_i,
	output video_config_t config_o
);
	logic access;
	logic enable_q;
	pix_fmt_e fmt_q;
	logic [29:0] fb_base_q;
	logic underflow_q;

	// an access is taken once, the cycle after it is the ack cycle
	assign access = cyc_i & stb_i & ~ack_o;

	always_ff @(posedge clk_i or negedge pixel_rstn_i) begin
		if (!pixel_rstn_i) begin
			ack_o <= 1'b0;
			dat_o <= '0;
			enable_q <= 1'b0;
			fmt_q <= PIX_RGB888;
			fb_base_q <= '0;
			underflow_q <= 1'b0;
		end else begin
			ack_o <= access;
			// read data is captured with the access and shown with ack
			if (access) begin
				case (adr_i)
					REG_CTRL: dat_o <= {30'b0, fmt_q, enable_q};
					REG_FB_BASE: dat_o <= {2'b0, fb_base_q};
					REG_STATUS: dat_o <= {30'b0, fetch_busy_i, underflow_q};
					default: dat_o <= '0;
				endcase
			end
			if (access && we_i && adr_i == REG_CTRL) begin
				enable_q <= dat_i[0];
				fmt_q <= pix_fmt_e'(dat_i[1]);
			end
			if (access && we_i && adr_i == REG_FB_BASE) begin
				fb_base_q <= dat_i[29:0];
			end
			// sticky underflow, a new underflow wins over the clear
			if (underflow_i) begin
				underflow_q <= 1'b1;
			end else if (access && we_i && adr_i == REG_STATUS && dat_i[0]) begin
				underflow_q <= 1'b0;
			end
		end
	end

	assign config_o = '{enable: enable_q, fmt: fmt_q, fb_base: fb_base_q};

endmodule

`default_nettype wire

// File: source/video_ifs.sv
`default_nettype none

`include "video_consts.svh"

// word path from the frame fetcher through the fifo to the unpacker
interface fb_fifo_if #(
	parameter int DEPTH = `VID_FIFO_DEPTH
);
	logic push;
	logic [31:0] wdata;
	// words held, 0 up to DEPTH
	logic [$clog2(DEPTH):0] level;
	logic pop;
	// head word, valid while empty is low
	logic [31:0] rdata;
	logic empty;

	modport writer (output push, output wdata, input level);
	modport reader (output pop, input rdata, input empty);
	modport fifo (input push, input wdata, input pop, output rdata, output empty, output level);
endinterface

// display counters and the pulses derived from them
interface vid_timing_if #(
	parameter int X_WIDTH = 10,
	parameter int Y_WIDTH = 10
);
	logic [X_WIDTH-1:0] x;
	logic [Y_WIDTH-1:0] y;
	logic de;
	logic hsync;
	logic vsync;
	logic frame_start;
	logic fetch_start;

	modport driver (output x, output y, output de, output hsync, output vsync,
		output frame_start, output fetch_start);
	// the fetcher only needs the start of vertical blanking
	modport fetch (input fetch_start);
	modport pixel (input x, input de, input hsync, input vsync, input frame_start,
		input fetch_start);
endinterface

`default_nettype wire

// File: source/video_pkg.sv
`default_nettype none

`include "video_consts.svh"

package video_pkg;

	// layout of one framebuffer word
	typedef enum logic {
		PIX_RGB888 = 1'b0,
		PIX_RGB565 = 1'b1
	} pix_fmt_e;

	// frame fetcher states
	typedef enum logic [1:0] {
		IDLE,
		FETCHING,
		FIFO_FULL,
		WAIT_OUTSTANDING
	} fetch_state_e;

	// register map of the config port
	typedef enum logic [1:0] {
		REG_CTRL = 2'(`VID_REG_CTRL),
		REG_FB_BASE = 2'(`VID_REG_FB_BASE),
		REG_STATUS = 2'(`VID_REG_STATUS)
	} cfg_reg_e;

	typedef struct packed {
		logic enable;
		pix_fmt_e fmt;
		// word address of the first pixel
		logic [29:0] fb_base;
	} video_config_t;

endpackage

`default_nettype wire

// File: include/video_consts.svh
`ifndef VIDEO_CONSTS_SVH
`define VIDEO_CONSTS_SVH

// default 640x480 mode, horizontal values in pixel clocks
`define VID_H_ACTIVE 640
`define VID_H_FRONT 16
`define VID_H_SYNC 96
`define VID_H_BACK 48

// vertical values in lines
`define VID_V_ACTIVE 480
`define VID_V_FRONT 10
`define VID_V_SYNC 2
`define VID_V_BACK 33

// pixel fifo size in 32-bit words
`define VID_FIFO_DEPTH 512

// word offsets on the config port
`define VID_REG_CTRL 0
`define VID_REG_FB_BASE 1
`define VID_REG_STATUS 2

`endif
